/* design/rename_pkg.sv */
`default_nettype none

package rename_pkg;

  // dispatch group and register file sizes
  localparam int DISP_SIZE = 2;
  localparam int ARCH_W    = 5;
  localparam int ARCH_SIZE = 1 << ARCH_W;
  localparam int RNID_SIZE = 64;
  localparam int RNID_W    = $clog2(RNID_SIZE);

  // free list layout: lane d owns FLIST_BASE + FLIST_SIZE*d upward
  localparam int FLIST_SIZE = 16;
  localparam int FLIST_BASE = 32;
  localparam int FLIST_W    = $clog2(FLIST_SIZE);
  localparam int TAG_W      = RNID_W - FLIST_W;  // upper id bits that select the lane

  // one instruction as it leaves dispatch, 18 bits
  typedef struct packed {
    logic              rs1_valid;
    logic [ARCH_W-1:0] rs1;
    logic              rs2_valid;
    logic [ARCH_W-1:0] rs2;
    logic              rd_valid;
    logic [ARCH_W-1:0] rd;
  } disp_inst_t;

  // one instruction after renaming, 27 bits
  typedef struct packed {
    logic              rs1_valid;
    logic [RNID_W-1:0] rs1_rnid;
    logic              rs2_valid;
    logic [RNID_W-1:0] rs2_rnid;
    logic              rd_valid;
    logic [RNID_W-1:0] rd_rnid;
    logic [RNID_W-1:0] old_rd_rnid;  // displaced id, freed later by retire
  } rename_inst_t;

  // id handed back by retire, 7 bits
  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rnid;
  } release_t;

endpackage

`default_nettype wire

/* design/rename_freelist.sv */
`timescale 1ns/1ps
`default_nettype none

// circular fifo of free physical ids, one per dispatch lane
module rename_freelist #(
  parameter int SIZE  = 16,
  parameter int WIDTH = 6,
  parameter int INIT  = 32
) (
  input  logic             i_clk,
  input  logic             i_rst_n,

  input  logic             i_push,
  input  logic [WIDTH-1:0] i_push_id,

  input  logic             i_pop,
  output logic [WIDTH-1:0] o_pop_id,
  output logic             o_empty
);

  typedef logic [$clog2(SIZE)-1:0]   ptr_t;
  typedef logic [$clog2(SIZE+1)-1:0] cnt_t;

  logic [WIDTH-1:0] mem_q [SIZE];
  ptr_t             head_q;
  ptr_t             tail_q;
  cnt_t             count_q;

  logic             full;
  logic             do_pop;
  logic             do_push;

  assign o_empty  = (count_q == '0);
  assign full     = (count_q == cnt_t'(SIZE));
  assign o_pop_id = mem_q[head_q];  // head is visible before the pop edge

  assign do_pop  = i_pop & ~o_empty;
  assign do_push = i_push & (~full | do_pop);  // a pop in the same cycle frees a slot

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      // preload INIT .. INIT+SIZE-1 in order
      for (int i = 0; i < SIZE; i++) begin
        mem_q[i] <= WIDTH'(INIT + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= cnt_t'(SIZE);
    end else begin
      if (do_push) begin
        mem_q[tail_q] <= i_push_id;
        if (int'(tail_q) == SIZE - 1) tail_q <= '0;
        else                          tail_q <= tail_q + 1'b1;
      end
      if (do_pop) begin
        if (int'(head_q) == SIZE - 1) head_q <= '0;
        else                          head_q <= head_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/rename_map.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_map import rename_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst_n,

  input  disp_inst_t        i_inst        [DISP_SIZE],
  input  logic              i_update,
  input  logic [RNID_W-1:0] i_new_rnid    [DISP_SIZE],

  output logic [RNID_W-1:0] o_rs1_rnid    [DISP_SIZE],
  output logic [RNID_W-1:0] o_rs2_rnid    [DISP_SIZE],
  output logic [RNID_W-1:0] o_old_rd_rnid [DISP_SIZE]
);

  logic [RNID_W-1:0] map_q [ARCH_SIZE];  // arch -> phys

  // table read
  logic [RNID_W-1:0] rs1_tbl [DISP_SIZE];
  logic [RNID_W-1:0] rs2_tbl [DISP_SIZE];
  logic [RNID_W-1:0] rd_tbl  [DISP_SIZE];

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      rs1_tbl[d] = map_q[i_inst[d].rs1];
      rs2_tbl[d] = map_q[i_inst[d].rs2];
      rd_tbl[d]  = map_q[i_inst[d].rd];
    end
  end

  // in-group bypass
  // an earlier lane writing the same arch reg overrides the table,
  // scanning upward so the nearest earlier writer is the one that sticks
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_rs1_rnid[d]    = rs1_tbl[d];
      o_rs2_rnid[d]    = rs2_tbl[d];
      o_old_rd_rnid[d] = rd_tbl[d];
      for (int e = 0; e < d; e++) begin
        if (i_inst[e].rd_valid) begin
          if (i_inst[e].rd == i_inst[d].rs1) o_rs1_rnid[d]    = i_new_rnid[e];
          if (i_inst[e].rd == i_inst[d].rs2) o_rs2_rnid[d]    = i_new_rnid[e];
          if (i_inst[e].rd == i_inst[d].rd)  o_old_rd_rnid[d] = i_new_rnid[e];
        end
      end
    end
  end

  // rd update, identity at reset
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int a = 0; a < ARCH_SIZE; a++) begin
        map_q[a] <= RNID_W'(a);
      end
    end else if (i_update) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_inst[d].rd_valid) begin
          map_q[i_inst[d].rd] <= i_new_rnid[d];  // later lane's write lands last
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_stage import rename_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst_n,

  // dispatch group in
  input  logic         i_disp_valid,
  input  disp_inst_t   i_disp    [DISP_SIZE],
  output logic         o_disp_ready,

  // renamed group out
  output logic         o_out_valid,
  output rename_inst_t o_out     [DISP_SIZE],
  input  logic         i_out_ready,

  // freed ids from retire
  input  release_t     i_release [DISP_SIZE]
);

  logic                 accept;
  logic                 out_free;
  logic                 lists_ok;
  logic [DISP_SIZE-1:0] rd_valid_vec;

  // free list side
  logic [DISP_SIZE-1:0] fl_pop;
  logic [DISP_SIZE-1:0] fl_empty;
  logic [RNID_W-1:0]    fl_pop_id  [DISP_SIZE];
  logic [DISP_SIZE-1:0] fl_push;
  logic [RNID_W-1:0]    fl_push_id [DISP_SIZE];

  // map side
  logic [RNID_W-1:0]    rs1_rnid    [DISP_SIZE];
  logic [RNID_W-1:0]    rs2_rnid    [DISP_SIZE];
  logic [RNID_W-1:0]    old_rd_rnid [DISP_SIZE];

  // output register
  logic                 out_valid_q;
  rename_inst_t         out_d [DISP_SIZE];
  rename_inst_t         out_q [DISP_SIZE];

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      rd_valid_vec[d] = i_disp[d].rd_valid;
    end
  end

  // register empty or drained this cycle
  assign out_free = ~out_valid_q | i_out_ready;
  // every lane that needs an rd id has one at its head
  assign lists_ok = ~|(rd_valid_vec & fl_empty);

  assign o_disp_ready = out_free & lists_ok;
  assign accept       = i_disp_valid & o_disp_ready;

  assign fl_pop = rd_valid_vec & {DISP_SIZE{accept}};

  // release steering
  // the upper id bits name the owning lane; ids in one cycle hit distinct lanes
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      fl_push[d]    = 1'b0;
      fl_push_id[d] = '0;
      for (int r = 0; r < DISP_SIZE; r++) begin
        if (i_release[r].valid &&
            i_release[r].rnid[RNID_W-1:FLIST_W] == TAG_W'(FLIST_BASE / FLIST_SIZE + d)) begin
          fl_push[d]    = 1'b1;
          fl_push_id[d] = i_release[r].rnid;
        end
      end
    end
  end

  generate
    for (genvar d_idx = 0; d_idx < DISP_SIZE; d_idx++) begin : g_lane
      rename_freelist #(
        .SIZE  (FLIST_SIZE),
        .WIDTH (RNID_W),
        .INIT  (FLIST_BASE + FLIST_SIZE * d_idx)
      ) u_freelist (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_push    (fl_push[d_idx]),
        .i_push_id (fl_push_id[d_idx]),
        .i_pop     (fl_pop[d_idx]),
        .o_pop_id  (fl_pop_id[d_idx]),
        .o_empty   (fl_empty[d_idx])
      );
    end
  endgenerate

  rename_map u_rename_map (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_inst        (i_disp),
    .i_update      (accept),
    .i_new_rnid    (fl_pop_id),     // head of each lane is the new rd id
    .o_rs1_rnid    (rs1_rnid),
    .o_rs2_rnid    (rs2_rnid),
    .o_old_rd_rnid (old_rd_rnid)
  );

  // pack results
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      out_d[d].rs1_valid   = i_disp[d].rs1_valid;
      out_d[d].rs1_rnid    = rs1_rnid[d];
      out_d[d].rs2_valid   = i_disp[d].rs2_valid;
      out_d[d].rs2_rnid    = rs2_rnid[d];
      out_d[d].rd_valid    = i_disp[d].rd_valid;
      out_d[d].rd_rnid     = fl_pop_id[d];
      out_d[d].old_rd_rnid = old_rd_rnid[d];
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (i_out_ready) begin
      out_valid_q <= 1'b0;  // taken, nothing new behind it
    end
  end

  // payload only moves on accept so a stalled result holds
  always_ff @(posedge i_clk) begin
    if (accept) begin
      out_q <= out_d;
    end
  end

  assign o_out_valid = out_valid_q;
  assign o_out       = out_q;

endmodule

`default_nettype wire

/* tb/rename_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// handshake and reset properties checked inside rename_stage
module rename_chk import rename_pkg::*; (
  input logic         i_clk,
  input logic         i_rst_n,
  input logic         i_disp_valid,
  input logic         o_disp_ready,
  input logic         o_out_valid,
  input rename_inst_t o_out [DISP_SIZE],
  input logic         i_out_ready
);

  localparam int INST_W = $bits(rename_inst_t);

  logic [DISP_SIZE*INST_W-1:0] out_flat;  // whole output group as one vector

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      out_flat[d*INST_W +: INST_W] = o_out[d];
    end
  end

  // first cycle out of reset
  a_reset_state: assert property (@(posedge i_clk)
    $rose(i_rst_n) |-> !o_out_valid && o_disp_ready)
    else $error("after reset o_out_valid=%b o_disp_ready=%b", o_out_valid, o_disp_ready);

  a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(out_flat))
    else $error("stalled output group changed or was dropped");

  a_accept_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_disp_valid && o_disp_ready |=> o_out_valid)
    else $error("accepted group did not show up on the output");

endmodule

`default_nettype wire

/* tb/rename_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int N_RAND       = 300;
  localparam int TOTAL_GROUPS = N_RAND + 60;

  logic         i_clk;
  logic         i_rst_n;
  logic         i_disp_valid;
  disp_inst_t   i_disp [DISP_SIZE];
  logic         o_disp_ready;
  logic         o_out_valid;
  rename_inst_t o_out [DISP_SIZE];
  logic         i_out_ready = 1'b1;
  release_t     i_release [DISP_SIZE] = '{default: '0};

  bit stall_en = 1'b0;  // random back-pressure on the output
  bit rel_en   = 1'b0;  // random releases of busy ids

  // reference model
  logic [RNID_W-1:0] shadow_map [ARCH_SIZE];
  logic [RNID_W-1:0] free_q [DISP_SIZE][$];
  logic [RNID_W-1:0] busy_q [DISP_SIZE][$];  // handed out, not yet released
  rename_inst_t      exp_q [$];              // DISP_SIZE entries per group

  rename_stage dut (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_disp_valid (i_disp_valid),
    .i_disp       (i_disp),
    .o_disp_ready (o_disp_ready),
    .o_out_valid  (o_out_valid),
    .o_out        (o_out),
    .i_out_ready  (i_out_ready),
    .i_release    (i_release)
  );

  bind rename_stage rename_chk u_chk (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_disp_valid (i_disp_valid),
    .o_disp_ready (o_disp_ready),
    .o_out_valid  (o_out_valid),
    .o_out        (o_out),
    .i_out_ready  (i_out_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(TOTAL_GROUPS * 20 * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d ns", TOTAL_GROUPS * 20 * CLK_PERIOD);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic compare_id(input logic [RNID_W-1:0] got, input logic [RNID_W-1:0] want,
                            input string what);
    assert (got === want) else begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
      $display("RESULT: FAIL");
      $fatal(1, "id mismatch");
    end
  endtask

  task automatic compare_bit(input logic got, input logic want, input string what);
    assert (got === want) else begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, want);
      $display("RESULT: FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic reset_model();
    for (int a = 0; a < ARCH_SIZE; a++) shadow_map[a] = RNID_W'(a);
    for (int d = 0; d < DISP_SIZE; d++) begin
      free_q[d].delete();
      busy_q[d].delete();
      for (int i = 0; i < FLIST_SIZE; i++) begin
        free_q[d].push_back(RNID_W'(FLIST_BASE + FLIST_SIZE * d + i));
      end
    end
    exp_q.delete();
  endtask

  task automatic check_handshake();
    logic want_ready;
    want_ready = (exp_q.size() == 0) || i_out_ready;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (i_disp[d].rd_valid && free_q[d].size() == 0) want_ready = 1'b0;
    end
    compare_bit(o_disp_ready, want_ready, "o_disp_ready");
    compare_bit(o_out_valid, exp_q.size() != 0, "o_out_valid");
  endtask

  task automatic check_taken_group();
    rename_inst_t want;
    for (int d = 0; d < DISP_SIZE; d++) begin
      want = exp_q.pop_front();
      compare_bit(o_out[d].rs1_valid, want.rs1_valid, $sformatf("lane %0d rs1_valid", d));
      compare_bit(o_out[d].rs2_valid, want.rs2_valid, $sformatf("lane %0d rs2_valid", d));
      compare_bit(o_out[d].rd_valid, want.rd_valid, $sformatf("lane %0d rd_valid", d));
      if (want.rs1_valid) begin
        compare_id(o_out[d].rs1_rnid, want.rs1_rnid, $sformatf("lane %0d rs1", d));
      end
      if (want.rs2_valid) begin
        compare_id(o_out[d].rs2_rnid, want.rs2_rnid, $sformatf("lane %0d rs2", d));
      end
      if (want.rd_valid) begin
        compare_id(o_out[d].rd_rnid, want.rd_rnid, $sformatf("lane %0d rd", d));
        compare_id(o_out[d].old_rd_rnid, want.old_rd_rnid, $sformatf("lane %0d old rd", d));
      end
    end
  endtask

  // lanes rename in order, so a later lane sees the earlier lane's new rd
  task automatic model_accept();
    rename_inst_t      want;
    logic [RNID_W-1:0] new_id;
    for (int d = 0; d < DISP_SIZE; d++) begin
      want             = '0;
      want.rs1_valid   = i_disp[d].rs1_valid;
      want.rs1_rnid    = shadow_map[i_disp[d].rs1];
      want.rs2_valid   = i_disp[d].rs2_valid;
      want.rs2_rnid    = shadow_map[i_disp[d].rs2];
      want.rd_valid    = i_disp[d].rd_valid;
      want.old_rd_rnid = shadow_map[i_disp[d].rd];
      if (i_disp[d].rd_valid) begin
        new_id       = free_q[d].pop_front();
        want.rd_rnid = new_id;
        shadow_map[i_disp[d].rd] = new_id;
        busy_q[d].push_back(new_id);
      end
      exp_q.push_back(want);
    end
  endtask

  task automatic model_release();
    int lane;
    for (int r = 0; r < DISP_SIZE; r++) begin
      if (i_release[r].valid) begin
        lane = (int'(i_release[r].rnid) - FLIST_BASE) / FLIST_SIZE;
        free_q[lane].push_back(i_release[r].rnid);
      end
    end
  endtask

  // one id per lane at most, slots randomly swapped to exercise the steering
  task automatic schedule_release();
    release_t rel [DISP_SIZE];
    int       pick;
    bit       swap;
    for (int d = 0; d < DISP_SIZE; d++) begin
      rel[d] = '0;
      if (rel_en && busy_q[d].size() > 0 && $urandom_range(1) == 1) begin
        pick         = $urandom_range(busy_q[d].size() - 1);
        rel[d].valid = 1'b1;
        rel[d].rnid  = busy_q[d][pick];
        busy_q[d].delete(pick);
      end
    end
    swap = ($urandom_range(1) == 1);
    for (int r = 0; r < DISP_SIZE; r++) begin
      i_release[r] <= swap ? rel[DISP_SIZE-1-r] : rel[r];
    end
  endtask

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      reset_model();
    end else begin
      check_handshake();
      if (o_out_valid && i_out_ready) check_taken_group();
      if (i_disp_valid && o_disp_ready) model_accept();
      model_release();
      schedule_release();
      i_out_ready <= stall_en ? ($urandom_range(2) != 0) : 1'b1;
    end
  end

  function automatic disp_inst_t make_inst(input bit v1, input int r1, input bit v2,
                                           input int r2, input bit vd, input int rd);
    disp_inst_t inst;
    inst.rs1_valid = v1;
    inst.rs1       = ARCH_W'(r1);
    inst.rs2_valid = v2;
    inst.rs2       = ARCH_W'(r2);
    inst.rd_valid  = vd;
    inst.rd        = ARCH_W'(rd);
    return inst;
  endfunction

  // small register range so groups often depend on each other
  function automatic disp_inst_t rand_inst();
    disp_inst_t inst;
    inst.rs1_valid = ($urandom_range(1) == 1);
    inst.rs1       = ARCH_W'($urandom_range(7));
    inst.rs2_valid = ($urandom_range(1) == 1);
    inst.rs2       = ARCH_W'($urandom_range(7));
    inst.rd_valid  = ($urandom_range(3) != 0);
    inst.rd        = ARCH_W'($urandom_range(7));
    return inst;
  endfunction

  // returns at the edge that accepts the group
  task automatic send_group(input disp_inst_t g0, input disp_inst_t g1);
    i_disp_valid <= 1'b1;
    i_disp[0]    <= g0;
    i_disp[1]    <= g1;
    @(posedge i_clk);
    while (!o_disp_ready) @(posedge i_clk);
  endtask

  task automatic idle_cycle();
    i_disp_valid <= 1'b0;
    @(posedge i_clk);
  endtask

  initial begin
    void'($urandom(78824));
    i_rst_n      = 1'b0;
    i_disp_valid = 1'b0;
    for (int d = 0; d < DISP_SIZE; d++) i_disp[d] = '0;
    repeat (8) @(posedge i_clk);
    i_rst_n <= 1'b1;
    idle_cycle();

    // identity sources, first ids 32 and 48
    send_group(make_inst(1, 3, 1, 4, 1, 3), make_inst(1, 7, 1, 8, 1, 9));
    // reads x3 renamed one group earlier, old rd of x3
    send_group(make_inst(1, 3, 1, 9, 1, 10), make_inst(1, 9, 0, 0, 1, 3));
    idle_cycle();
    // lane 1 reads and rewrites lane 0's x5
    send_group(make_inst(0, 0, 0, 0, 1, 5), make_inst(1, 5, 1, 5, 1, 5));
    send_group(make_inst(1, 5, 0, 0, 0, 0), make_inst(1, 5, 0, 0, 0, 0));

    stall_en <= 1'b1;
    rel_en   <= 1'b1;
    for (int n = 0; n < N_RAND; n++) begin
      send_group(rand_inst(), rand_inst());
      if ($urandom_range(3) == 0) idle_cycle();
    end

    // drain lane 0 without releases until dispatch stalls
    stall_en     <= 1'b0;
    rel_en       <= 1'b0;
    i_disp_valid <= 1'b1;
    i_disp[0]    <= make_inst(1, 1, 0, 0, 1, 2);
    i_disp[1]    <= make_inst(1, 2, 0, 0, 0, 0);
    @(posedge i_clk);
    while (o_disp_ready || !i_out_ready) @(posedge i_clk);
    repeat (3) @(posedge i_clk);
    rel_en <= 1'b1;  // freed ids reopen the lane
    while (!o_disp_ready) @(posedge i_clk);
    for (int n = 0; n < 12; n++) send_group(rand_inst(), rand_inst());

    i_disp_valid <= 1'b0;
    rel_en       <= 1'b0;
    @(posedge i_clk);
    while (o_out_valid) @(posedge i_clk);
    repeat (2) @(posedge i_clk);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
design/rename_pkg.sv
design/rename_freelist.sv
design/rename_map.sv
design/rename_stage.sv
tb/rename_chk.sv
tb/rename_tb.sv

/* run.sh */
#!/bin/sh
# build the rename stage testbench with verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f build.f --top-module rename_tb -o rename_sim \
  && ./obj_dir/rename_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^RESULT: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
